//--- design/loadAlign.sv
/*
 * Load data aligner.
 * Takes the word read from data memory and the low address bits, picks the
 * addressed byte or halfword and extends it to 32 bits by load type.
 * Purely combinational.
 */

`timescale 1ns/100ps

module loadAlign import wbPkg::*; (
    input  logic [31:0] dmOut,
    input  logic [1:0]  byteAddr,
    input  LoadType     loadType,
    output logic [31:0] loadResult
);

    LoadWord     word;                      // Same bits as dmOut, two views
    logic [7:0]  selByte;
    logic [15:0] selHalf;

    assign word = dmOut;

    // Little-endian lane select
    assign selByte = word.bytes[byteAddr];
    assign selHalf = word.halves[byteAddr[1]]; // Bit 0 ignored for halfwords

    always_comb begin
        unique case (loadType)
            loadByte: begin
                loadResult = {{24{selByte[7]}}, selByte};
            end
            loadByteU: begin
                loadResult = {24'd0, selByte};
            end
            loadHalf: begin
                loadResult = {{16{selHalf[15]}}, selHalf};
            end
            loadHalfU: begin
                loadResult = {16'd0, selHalf};
            end
            default: begin
                loadResult = word;          // LW and non-loads
            end
        endcase
    end

endmodule

//--- design/memWbReg.sv
/*
 * Pipeline register between the memory and writeback stages.
 * Copies every memory-stage field on each rising clock edge.
 * Reset or a flush turns the slot into a bubble by clearing the write enables.
 */

`timescale 1ns/100ps

module memWbReg import wbPkg::*; #(
    parameter  int NUM_REGS = 32,
    localparam int ADDR_W   = $clog2(NUM_REGS)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              wbFlush,
    input  logic [31:0]       memAluOut,
    input  logic [31:0]       memHi,
    input  logic [31:0]       memLo,
    input  logic [31:0]       memPc,
    input  logic [31:0]       memOutB,
    input  logic [31:0]       memDmOut,
    input  WbSel              memWbSel,
    input  LoadType           memLoadType,
    input  logic [ADDR_W-1:0] memDst,
    input  logic              memRegWr,
    input  logic              memHiWr,
    input  logic              memLoWr,
    output logic [31:0]       wbAluOut,
    output logic [31:0]       wbHi,
    output logic [31:0]       wbLo,
    output logic [31:0]       wbPc,
    output logic [31:0]       wbOutB,
    output logic [31:0]       wbDmOut,
    output WbSel              wbWbSel,
    output LoadType           wbLoadType,
    output logic [ADDR_W-1:0] wbDst,
    output logic              wbRegWr,
    output logic              wbHiWr,
    output logic              wbLoWr
);

    // Write enables decide whether the slot holds a real instruction
    always_ff @(posedge clk) begin
        if (reset || wbFlush) begin
            wbRegWr <= 1'b0;                // Bubble
            wbHiWr  <= 1'b0;
            wbLoWr  <= 1'b0;
        end else begin
            wbRegWr <= memRegWr;
            wbHiWr  <= memHiWr;
            wbLoWr  <= memLoWr;
        end
    end

    // Payload follows the memory stage every cycle
    // and is ignored while the enables are low
    always_ff @(posedge clk) begin
        wbAluOut   <= memAluOut;
        wbHi       <= memHi;
        wbLo       <= memLo;
        wbPc       <= memPc;
        wbOutB     <= memOutB;
        wbDmOut    <= memDmOut;
        wbWbSel    <= memWbSel;
        wbLoadType <= memLoadType;
        wbDst      <= memDst;
    end

endmodule

//--- design/regCommit.sv
/*
 * Writeback commit block.
 * Picks the writeback value from four sources and commits it to the general
 * register file, and updates HI and LO from their own enables.
 * Register 0 always reads zero. One combinational debug read port.
 */

`timescale 1ns/100ps

module regCommit import wbPkg::*; #(
    parameter  int NUM_REGS = 32,
    localparam int ADDR_W   = $clog2(NUM_REGS)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       pc,
    input  logic [31:0]       aluOut,
    input  logic [31:0]       outB,
    input  logic [31:0]       loadResult,
    input  logic [31:0]       hiIn,
    input  logic [31:0]       loIn,
    input  WbSel              wbSel,
    input  logic [ADDR_W-1:0] dst,
    input  logic              regWr,
    input  logic              hiWr,
    input  logic              loWr,
    input  logic [ADDR_W-1:0] readAddr,
    output logic [31:0]       result,
    output logic [31:0]       hiValue,
    output logic [31:0]       loValue,
    output logic [31:0]       readData
);

    logic [31:0] regs [NUM_REGS];          // General register file
    logic [31:0] hiReg;
    logic [31:0] loReg;
    logic        regWrEn;

    // Writeback source select, also the forwarding value
    always_comb begin
        unique case (wbSel)
            wbLink:  result = pc + 32'd8;   // Return address past the delay slot
            wbAlu:   result = aluOut;
            wbOutB:  result = outB;
            default: result = loadResult;   // wbMem
        endcase
    end

    assign regWrEn = regWr && (dst != '0); // Writes to register 0 are dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (regWrEn) begin
            regs[dst] <= result;
        end
    end

    // HI and LO have their own enables, independent of regWr
    always_ff @(posedge clk) begin
        if (reset) begin
            hiReg <= 32'd0;
            loReg <= 32'd0;
        end else begin
            if (hiWr) begin
                hiReg <= hiIn;
            end
            if (loWr) begin
                loReg <= loIn;
            end
        end
    end

    assign hiValue  = hiReg;
    assign loValue  = loReg;
    assign readData = regs[readAddr];      // Register 0 is never written

endmodule

//--- design/wbPkg.sv
/*
 * Shared types for the writeback stage.
 * Load-type and writeback-select encodings, plus the union that lets the
 * load aligner view one data word either as bytes or as halfwords.
 * RTL and testbench pull these in with a wildcard import.
 */

package wbPkg;

    // How the word returned by data memory is used
    typedef enum logic [2:0] {
        loadWord  = 3'd0,                   // Full word, also used by non-loads
        loadByte  = 3'd1,                   // LB, sign extended
        loadByteU = 3'd2,                   // LBU, zero extended
        loadHalf  = 3'd3,                   // LH, sign extended
        loadHalfU = 3'd4                    // LHU, zero extended
    } LoadType;

    // Source of the value written back to the register file
    typedef enum logic [1:0] {
        wbLink = 2'b00,                     // PC+8 for JAL and JALR
        wbAlu  = 2'b01,                     // ALU result
        wbOutB = 2'b10,                     // Operand B for move-type instructions
        wbMem  = 2'b11                      // Aligned load result
    } WbSel;

    // One loaded word, decoded by byte or by halfword
    typedef union packed {
        logic [3:0][7:0]  bytes;            // bytes[0] is bits 7:0
        logic [1:0][15:0] halves;           // halves[0] is bits 15:0
    } LoadWord;

endpackage

//--- design/wbStage.sv
/*
 * Writeback stage top level.
 * Chains the MEM/WB register, the load aligner and the commit block.
 * Exports the destination, write enable and result of the instruction in
 * writeback for bypassing in earlier stages.
 */

`timescale 1ns/100ps

module wbStage import wbPkg::*; #(
    parameter  int NUM_REGS = 32,
    localparam int ADDR_W   = $clog2(NUM_REGS)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              wbFlush,
    input  logic [31:0]       memAluOut,
    input  logic [31:0]       memHi,
    input  logic [31:0]       memLo,
    input  logic [31:0]       memPc,
    input  logic [31:0]       memOutB,
    input  logic [31:0]       memDmOut,
    input  WbSel              memWbSel,
    input  LoadType           memLoadType,
    input  logic [ADDR_W-1:0] memDst,
    input  logic              memRegWr,
    input  logic              memHiWr,
    input  logic              memLoWr,
    input  logic [ADDR_W-1:0] readAddr,
    output logic [31:0]       wbResult,
    output logic [ADDR_W-1:0] wbDst,
    output logic              wbRegWr,
    output logic [31:0]       hiValue,
    output logic [31:0]       loValue,
    output logic [31:0]       readData
);

    logic [31:0] wbAluOut;
    logic [31:0] wbHi;
    logic [31:0] wbLo;
    logic [31:0] wbPc;
    logic [31:0] wbOutB;
    logic [31:0] wbDmOut;
    WbSel        wbWbSel;
    LoadType     wbLoadType;
    logic        wbHiWr;
    logic        wbLoWr;
    logic [31:0] loadResult;

    memWbReg #(
        .NUM_REGS   (NUM_REGS)
    ) uMemWbReg (
        .clk        (clk),
        .reset      (reset),
        .wbFlush    (wbFlush),
        .memAluOut  (memAluOut),
        .memHi      (memHi),
        .memLo      (memLo),
        .memPc      (memPc),
        .memOutB    (memOutB),
        .memDmOut   (memDmOut),
        .memWbSel   (memWbSel),
        .memLoadType(memLoadType),
        .memDst     (memDst),
        .memRegWr   (memRegWr),
        .memHiWr    (memHiWr),
        .memLoWr    (memLoWr),
        .wbAluOut   (wbAluOut),
        .wbHi       (wbHi),
        .wbLo       (wbLo),
        .wbPc       (wbPc),
        .wbOutB     (wbOutB),
        .wbDmOut    (wbDmOut),
        .wbWbSel    (wbWbSel),
        .wbLoadType (wbLoadType),
        .wbDst      (wbDst),            // Forwarding output
        .wbRegWr    (wbRegWr),          // Forwarding output
        .wbHiWr     (wbHiWr),
        .wbLoWr     (wbLoWr)
    );

    loadAlign uLoadAlign (
        .dmOut      (wbDmOut),
        .byteAddr   (wbAluOut[1:0]),    // Load address comes from the ALU
        .loadType   (wbLoadType),
        .loadResult (loadResult)
    );

    regCommit #(
        .NUM_REGS   (NUM_REGS)
    ) uRegCommit (
        .clk        (clk),
        .reset      (reset),
        .pc         (wbPc),
        .aluOut     (wbAluOut),
        .outB       (wbOutB),
        .loadResult (loadResult),
        .hiIn       (wbHi),
        .loIn       (wbLo),
        .wbSel      (wbWbSel),
        .dst        (wbDst),
        .regWr      (wbRegWr),
        .hiWr       (wbHiWr),
        .loWr       (wbLoWr),
        .readAddr   (readAddr),
        .result     (wbResult),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .readData   (readData)
    );

endmodule

//--- flist.f
design/wbPkg.sv
design/memWbReg.sv
design/loadAlign.sv
design/regCommit.sv
design/wbStage.sv
tests/wbStageTb.sv

//--- tests/wbStageTb.sv
/*
 * Directed testbench for the writeback stage.
 * Issues one instruction per cycle and keeps its own register and HI/LO model.
 * Forwarding outputs are checked one cycle after issue, and the committed
 * register is read back one cycle later. Run with flist.f, top wbStageTb.
 */

`timescale 1ns/100ps

module wbStageTb import wbPkg::*; ();

    localparam logic [31:0] LFSR_SEED  = 32'h2ce2;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    // Tests take about 1100 cycles, so this leaves close to a factor of two
    localparam int          MAX_CYCLES = 2000;

    // One issued instruction as the scoreboard sees it
    typedef struct packed {
        logic        valid;
        logic [4:0]  dst;
        logic        regWr;
        logic        hiWr;
        logic        loWr;
        logic        flush;
        logic [31:0] result;
        logic [31:0] hi;
        logic [31:0] lo;
    } InstrRec;

    logic        clk;
    logic        reset;
    logic        wbFlush;
    logic [31:0] memAluOut;
    logic [31:0] memHi;
    logic [31:0] memLo;
    logic [31:0] memPc;
    logic [31:0] memOutB;
    logic [31:0] memDmOut;
    WbSel        memWbSel;
    LoadType     memLoadType;
    logic [4:0]  memDst;
    logic        memRegWr;
    logic        memHiWr;
    logic        memLoWr;
    logic [4:0]  readAddr;
    logic [31:0] wbResult;
    logic [4:0]  wbDst;
    logic        wbRegWr;
    logic [31:0] hiValue;
    logic [31:0] loValue;
    logic [31:0] readData;

    logic [31:0] model [32];                // Expected register file
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] lfsrState;
    InstrRec     inFlight;                  // Issued last, sits in MEM/WB next
    InstrRec     committing;                // Issued before that, commits now
    string       testName;
    int          cycleCount;

    wbStage #(
        .NUM_REGS   (32)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .wbFlush    (wbFlush),
        .memAluOut  (memAluOut),
        .memHi      (memHi),
        .memLo      (memLo),
        .memPc      (memPc),
        .memOutB    (memOutB),
        .memDmOut   (memDmOut),
        .memWbSel   (memWbSel),
        .memLoadType(memLoadType),
        .memDst     (memDst),
        .memRegWr   (memRegWr),
        .memHiWr    (memHiWr),
        .memLoWr    (memLoWr),
        .readAddr   (readAddr),
        .wbResult   (wbResult),
        .wbDst      (wbDst),
        .wbRegWr    (wbRegWr),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .readData   (readData)
    );

    always #4 clk = ~clk;                   // 8 ns period

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Simulation ran past %0d cycles without finishing", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] nextBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            if (lfsrState[0]) begin
                lfsrState = (lfsrState >> 1) ^ LFSR_TAPS;
            end else begin
                lfsrState = lfsrState >> 1;
            end
        end
        return bits;
    endfunction

    // Little-endian byte or halfword pick, then extension by load type
    function automatic logic [31:0] alignLoad(input logic [31:0] word,
                                              input logic [1:0] addr,
                                              input LoadType lt);
        logic [7:0]  b;
        logic [15:0] h;
        b = word >> (8 * addr);
        h = word >> (16 * addr[1]);
        case (lt)
            loadByte:  return {{24{b[7]}}, b};
            loadByteU: return {24'd0, b};
            loadHalf:  return {{16{h[15]}}, h};
            loadHalfU: return {16'd0, h};
            default:   return word;
        endcase
    endfunction

    function automatic logic [31:0] expectedResult(input WbSel sel, input LoadType lt,
                                                   input logic [31:0] alu,
                                                   input logic [31:0] pc,
                                                   input logic [31:0] outB,
                                                   input logic [31:0] dm);
        case (sel)
            wbLink:  return pc + 32'd8;
            wbAlu:   return alu;
            wbOutB:  return outB;
            default: return alignLoad(dm, alu[1:0], lt);
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic commitToModel(input InstrRec rec);
        if (rec.valid && !rec.flush) begin
            if (rec.regWr && rec.dst != 5'd0) begin
                model[rec.dst] = rec.result;
            end
            if (rec.hiWr) begin
                modelHi = rec.hi;
            end
            if (rec.loWr) begin
                modelLo = rec.lo;
            end
        end
    endtask

    task automatic checkForwarding(input InstrRec rec);
        logic live;
        live = rec.regWr && !rec.flush;     // Flushed slot must show no write
        if (rec.valid) begin
            checkValue("wbRegWr", live, wbRegWr);
            if (live) begin
                checkValue("wbDst", rec.dst, wbDst);
                checkValue("wbResult", rec.result, wbResult);
            end
        end
    endtask

    // Drives one instruction and checks the two older ones still in flight
    task automatic issueInstr(input WbSel sel, input LoadType lt, input logic [4:0] dst,
                              input logic regWr, input logic hiWr, input logic loWr,
                              input logic flush, input logic [31:0] alu,
                              input logic [31:0] pc, input logic [31:0] outB,
                              input logic [31:0] dm, input logic [31:0] hi,
                              input logic [31:0] lo);
        InstrRec rec;
        rec.valid  = 1'b1;
        rec.dst    = dst;
        rec.regWr  = regWr;
        rec.hiWr   = hiWr;
        rec.loWr   = loWr;
        rec.flush  = flush;
        rec.result = expectedResult(sel, lt, alu, pc, outB, dm);
        rec.hi     = hi;
        rec.lo     = lo;
        @(posedge clk);
        commitToModel(committing);          // Its write lands on this edge
        memWbSel    <= sel;
        memLoadType <= lt;
        memDst      <= dst;
        memRegWr    <= regWr;
        memHiWr     <= hiWr;
        memLoWr     <= loWr;
        wbFlush     <= flush;
        memAluOut   <= alu;
        memPc       <= pc;
        memOutB     <= outB;
        memDmOut    <= dm;
        memHi       <= hi;
        memLo       <= lo;
        readAddr    <= committing.dst;
        @(negedge clk);
        checkForwarding(inFlight);
        if (committing.valid) begin
            checkValue("readback", model[committing.dst], readData);
            checkValue("hiValue", modelHi, hiValue);
            checkValue("loValue", modelLo, loValue);
        end
        committing = inFlight;
        inFlight   = rec;
    endtask

    // Two bubbles push the last real instruction through commit
    task automatic drainPipe();
        repeat (2) begin
            issueInstr(wbAlu, loadWord, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0,
                       32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0);
        end
    endtask

    task automatic compareAllRegs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            readAddr <= i[4:0];
            @(negedge clk);
            checkValue($sformatf("r%0d", i), model[i], readData);
        end
        checkValue("hiValue", modelHi, hiValue);
        checkValue("loValue", modelLo, loValue);
    endtask

    task automatic afterResetTest();
        testName = "afterReset";
        @(negedge clk);
        checkValue("wbRegWr", 32'd0, wbRegWr);
        compareAllRegs();
    endtask

    task automatic sourceSelectTest();
        testName = "sourceSelect";
        issueInstr(wbLink, loadWord, 5'd1, 1'b1, 1'b0, 1'b0, 1'b0, nextBits(32),
                   nextBits(32), nextBits(32), nextBits(32), 32'd0, 32'd0);
        issueInstr(wbAlu, loadWord, 5'd2, 1'b1, 1'b0, 1'b0, 1'b0, nextBits(32),
                   nextBits(32), nextBits(32), nextBits(32), 32'd0, 32'd0);
        issueInstr(wbOutB, loadWord, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0, nextBits(32),
                   nextBits(32), nextBits(32), nextBits(32), 32'd0, 32'd0);
        issueInstr(wbMem, loadWord, 5'd4, 1'b1, 1'b0, 1'b0, 1'b0, nextBits(32),
                   nextBits(32), nextBits(32), nextBits(32), 32'd0, 32'd0);
        drainPipe();
        compareAllRegs();
    endtask

    task automatic loadAlignTest();
        logic [31:0] word;
        logic [31:0] addr;
        logic [4:0]  dst;
        logic [2:0]  ltCode;
        testName = "loadAlign";
        dst = 5'd1;
        for (int w = 0; w < 40; w++) begin
            word = nextBits(32);
            for (int a = 0; a < 4; a++) begin
                for (int t = 0; t < 5; t++) begin
                    addr      = nextBits(30) << 2;
                    addr[1:0] = a[1:0];
                    ltCode    = t[2:0];
                    issueInstr(wbMem, LoadType'(ltCode), dst, 1'b1, 1'b0, 1'b0, 1'b0,
                               addr, 32'd0, 32'd0, word, 32'd0, 32'd0);
                    dst = (dst == 5'd31) ? 5'd1 : dst + 5'd1;   // Skip r0
                end
            end
        end
        drainPipe();
        compareAllRegs();
    endtask

    task automatic hiLoTest();
        testName = "hiLo";
        issueInstr(wbAlu, loadWord, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0, 32'd0, 32'd0,
                   32'd0, 32'd0, nextBits(32), nextBits(32));
        issueInstr(wbAlu, loadWord, 5'd0, 1'b0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0,
                   32'd0, 32'd0, nextBits(32), nextBits(32));
        issueInstr(wbAlu, loadWord, 5'd0, 1'b0, 1'b1, 1'b1, 1'b0, 32'd0, 32'd0,
                   32'd0, 32'd0, nextBits(32), nextBits(32));
        // Register write only, HI and LO data present but not enabled
        issueInstr(wbAlu, loadWord, 5'd5, 1'b1, 1'b0, 1'b0, 1'b0, nextBits(32),
                   32'd0, 32'd0, 32'd0, nextBits(32), nextBits(32));
        drainPipe();
        compareAllRegs();
    endtask

    task automatic flushZeroTest();
        testName = "flushZero";
        issueInstr(wbAlu, loadWord, 5'd7, 1'b1, 1'b1, 1'b1, 1'b1, nextBits(32),
                   32'd0, 32'd0, 32'd0, nextBits(32), nextBits(32));
        issueInstr(wbAlu, loadWord, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
                   nextBits(32) | 32'd1, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0);
        drainPipe();
        @(posedge clk);
        readAddr <= 5'd0;
        @(negedge clk);
        checkValue("r0", 32'd0, readData);
        compareAllRegs();
    endtask

    task automatic backToBackTest();
        logic [1:0] selCode;
        logic [2:0] ltCode;
        logic [4:0] dst;
        testName = "backToBack";
        for (int n = 0; n < 20; n++) begin
            selCode = nextBits(2);
            ltCode  = nextBits(3) % 5;
            dst     = nextBits(5);
            issueInstr(WbSel'(selCode), LoadType'(ltCode), dst, 1'b1, nextBits(1),
                       nextBits(1), 1'b0, nextBits(32), nextBits(32), nextBits(32),
                       nextBits(32), nextBits(32), nextBits(32));
        end
        drainPipe();
        compareAllRegs();
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        wbFlush     = 1'b0;
        memAluOut   = 32'd0;
        memHi       = 32'd0;
        memLo       = 32'd0;
        memPc       = 32'd0;
        memOutB     = 32'd0;
        memDmOut    = 32'd0;
        memWbSel    = wbAlu;
        memLoadType = loadWord;
        memDst      = 5'd0;
        memRegWr    = 1'b0;
        memHiWr     = 1'b0;
        memLoWr     = 1'b0;
        readAddr    = 5'd0;
        lfsrState   = LFSR_SEED;
        inFlight    = '0;
        committing  = '0;
        cycleCount  = 0;
        modelHi     = 32'd0;
        modelLo     = 32'd0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        testName = "reset";

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        afterResetTest();
        sourceSelectTest();
        loadAlignTest();
        hiLoTest();
        flushZeroTest();
        backToBackTest();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
